// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_adcfifo
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: adc_capture_ctrl.sv
`timescale 1ns/100ps

module adc_capture_ctrl (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  logic                     trig,          // one-cycle capture start
  input  logic                     adc_valid,     // sample strobe
  input  adcfifo_pkg::adc_sample_t adc_data,
  input  adcfifo_pkg::seg_len_t    seg_len,       // samples per capture
  output logic                     push,          // fifo write
  output adcfifo_pkg::adc_sample_t push_data,
  output logic                     capture_done   // segment complete
);

  import adcfifo_pkg::*;

  capture_state_t state;
  seg_len_t       count;        // samples pushed in this run
  seg_len_t       count_next;

  assign push       = (state == ARMED_RUN) && adc_valid;  // no back-pressure
  assign push_data  = adc_data;
  assign count_next = count + 1'b1;

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (trig) begin
            count <= '0;
            // empty segment completes at once
            state <= (seg_len == '0) ? DONE : ARMED_RUN;
          end
        end
        ARMED_RUN: begin
          if (push) begin
            count <= count_next;
            if (count_next == seg_len)
              state <= DONE;  // last sample of the segment
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // high from the cycle after the last push until the next trigger
  assign capture_done = (state == DONE);

endmodule

// File: adc_sample_fifo.sv
`timescale 1ns/100ps

module adc_sample_fifo (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  logic                     push,                // write strobe from capture
  input  adcfifo_pkg::adc_sample_t push_data,
  input  logic                     pop,                 // read strobe from register block
  input  logic                     fast_mode,
  input  logic                     no_underflow_errors,
  input  logic                     clear_errors,
  output adcfifo_pkg::adc_sample_t head_sample,         // fwft output
  output logic                     empty,
  output adcfifo_pkg::fifo_err_t   err_stat,
  output adcfifo_pkg::reg_byte_t   underflow_count,     // saturating
  output logic [31:0]              read_count,
  output logic [31:0]              read_count_freeze
);

  import adcfifo_pkg::*;

  typedef logic [FIFO_AW:0] ptr_t;  // extra msb tells full from empty

  adc_sample_t mem [FIFO_DEPTH];
  ptr_t        wr_ptr;
  ptr_t        rd_ptr;
  logic        full;
  logic        push_ok;          // accepted write
  logic        pop_ok;           // accepted read
  logic        underflow;        // pop while empty
  fifo_err_t   err_set;          // new error events this cycle
  logic [31:0] read_count_next;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  assign push_ok   = push && !full;   // push while full is lost
  assign pop_ok    = pop && !empty;   // empty pop leaves pointer alone
  assign underflow = pop && empty;

  // storage, head read straight out
  always_ff @(posedge clk_usb) begin
    if (push_ok)
      mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
  end

  assign head_sample = mem[rd_ptr[FIFO_AW-1:0]];

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // error classification by mode and policy
  always_comb begin
    err_set                     = '0;
    err_set[ERR_OVERFLOW]       = push && full;
    err_set[ERR_UNDERFLOW_FAST] = underflow && fast_mode;
    err_set[ERR_UNDERFLOW_SLOW] = underflow && !fast_mode && !no_underflow_errors;
  end

  // sticky until cleared, a same-cycle event still lands
  always_ff @(posedge clk_usb) begin
    if (reset)
      err_stat <= '0;
    else
      err_stat <= (clear_errors ? fifo_err_t'(0) : err_stat) | err_set;
  end

  // counted in every mode, whatever the policy
  always_ff @(posedge clk_usb) begin
    if (reset)
      underflow_count <= '0;
    else if (underflow && (underflow_count != 8'hFF))
      underflow_count <= underflow_count + 1'b1;
  end

  assign read_count_next = read_count + {31'b0, pop_ok};

  // debug pop counters
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_count        <= '0;
      read_count_freeze <= '0;
    end else begin
      read_count <= read_count_next;
      if ((err_stat == '0) || clear_errors)
        read_count_freeze <= read_count_next;  // holds once flagged, clear releases
    end
  end

endmodule

// File: adcfifo_chk.sv
`timescale 1ns/100ps

module adcfifo_chk (
  input logic                  clk_usb,
  input logic                  reset,
  input adcfifo_pkg::reg_bus_t reg_bus,
  input logic                  pop,
  input logic                  clear_errors,
  input logic                  fast_mode,
  input logic                  no_underflow_errors,
  input logic                  capture_done,
  input logic                  low_res,
  input logic                  low_res_lsb,
  input adcfifo_pkg::seg_len_t seg_len
);

  import adcfifo_pkg::*;

  int   fail_count = 0;  // read by the testbench at the end
  logic sample_read;     // host reading the sample address

  assign sample_read = reg_bus.read && (reg_bus.address == ADDR_ADCREAD);

  pop_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
    pop && !fast_mode |=> !pop)
  else begin
    $error("slow-mode pop held longer than one cycle");
    fail_count++;
  end

  clear_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
    clear_errors |=> !clear_errors)
  else begin
    $error("clear_errors held longer than one cycle");
    fail_count++;
  end

  // slow pop trails the read rise by one cycle
  pop_needs_read: assert property (@(posedge clk_usb) disable iff (reset)
    pop |-> sample_read || $past(sample_read))
  else begin
    $error("pop without a read of the sample address");
    fail_count++;
  end

  reset_values: assert property (@(posedge clk_usb)
    $fell(reset) |-> !pop && !clear_errors && !fast_mode && !capture_done &&
                     no_underflow_errors && !low_res && !low_res_lsb &&
                     (seg_len == SEG_LEN_RESET))
  else begin
    $error("register block not at reset values after reset");
    fail_count++;
  end

endmodule

bind reg_adcfifo adcfifo_chk i_adcfifo_chk (.*);

// File: adcfifo_pkg.sv
package adcfifo_pkg;

  localparam int BYTECNT_W  = 7;   // byte index within a multibyte register
  localparam int FIFO_DEPTH = 32;  // sample entries
  localparam int FIFO_AW    = 5;   // log2 of FIFO_DEPTH

  // bit positions in the error status byte
  localparam int ERR_OVERFLOW       = 0;  // push while full
  localparam int ERR_UNDERFLOW_FAST = 1;  // pop while empty, fast mode
  localparam int ERR_UNDERFLOW_SLOW = 2;  // pop while empty, slow mode, policy 0

  typedef logic [7:0]           reg_addr_t;    // register address
  typedef logic [7:0]           reg_byte_t;    // one bus data byte
  typedef logic [BYTECNT_W-1:0] bytecnt_t;     // byte index, little endian
  typedef logic [9:0]           adc_sample_t;  // raw adc sample
  typedef logic [16:0]          seg_len_t;     // segment length in samples
  typedef logic [7:0]           fifo_err_t;    // fifo error flags

  localparam seg_len_t SEG_LEN_RESET = 17'd65536;

  // register map
  localparam reg_addr_t ADDR_ADCREAD                  = 8'd3;
  localparam reg_addr_t ADDR_FIFO_STAT                = 8'd4;
  localparam reg_addr_t ADDR_ADC_LOW_RES              = 8'd5;
  localparam reg_addr_t ADDR_FAST_FIFO_READ_MODE      = 8'd6;
  localparam reg_addr_t ADDR_STREAM_SEGMENT_THRESHOLD = 8'd7;
  localparam reg_addr_t ADDR_FIFO_UNDERFLOW_COUNT     = 8'd8;
  localparam reg_addr_t ADDR_FIFO_NO_UNDERFLOW_ERROR  = 8'd9;
  localparam reg_addr_t ADDR_CAPTURE_DONE             = 8'd10;
  localparam reg_addr_t ADDR_DEBUG_FIFO_READS         = 8'd11;
  localparam reg_addr_t ADDR_DEBUG_FIFO_READS_FREEZE  = 8'd12;

  // host register bus, one bundle
  typedef struct packed {
    reg_addr_t address;  // register being accessed
    bytecnt_t  bytecnt;  // byte of a multibyte register
    reg_byte_t datai;    // write data
    logic      read;     // held high while host samples read data
    logic      write;    // one-cycle write strobe
  } reg_bus_t;

  // capture controller states
  typedef enum logic [1:0] {
    IDLE,       // waiting for first trigger
    ARMED_RUN,  // pushing valid samples
    DONE        // segment complete
  } capture_state_t;

endpackage

// File: adcfifo_top.sv
`timescale 1ns/100ps

module adcfifo_top (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  adcfifo_pkg::reg_bus_t    reg_bus,    // host register bus
  output adcfifo_pkg::reg_byte_t   reg_datao,
  input  logic                     trig,
  input  logic                     adc_valid,
  input  adcfifo_pkg::adc_sample_t adc_data
);

  import adcfifo_pkg::*;

  // capture to fifo
  logic        push;
  adc_sample_t push_data;
  // fifo to register block
  adc_sample_t head_sample;
  logic        empty;
  fifo_err_t   err_stat;
  reg_byte_t   underflow_count;
  logic [31:0] read_count;
  logic [31:0] read_count_freeze;
  // register block to fifo and capture
  logic        pop;
  logic        clear_errors;
  logic        fast_mode;
  logic        no_underflow_errors;
  seg_len_t    seg_len;
  logic        capture_done;

  reg_adcfifo i_reg_adcfifo (
    .clk_usb             (clk_usb),
    .reset               (reset),
    .reg_bus             (reg_bus),
    .reg_datao           (reg_datao),
    .head_sample         (head_sample),
    .empty               (empty),
    .err_stat            (err_stat),
    .underflow_count     (underflow_count),
    .read_count          (read_count),
    .read_count_freeze   (read_count_freeze),
    .capture_done        (capture_done),
    .pop                 (pop),
    .clear_errors        (clear_errors),
    .fast_mode           (fast_mode),
    .no_underflow_errors (no_underflow_errors),
    .seg_len             (seg_len)
  );

  adc_sample_fifo i_adc_sample_fifo (
    .clk_usb             (clk_usb),
    .reset               (reset),
    .push                (push),
    .push_data           (push_data),
    .pop                 (pop),
    .fast_mode           (fast_mode),
    .no_underflow_errors (no_underflow_errors),
    .clear_errors        (clear_errors),
    .head_sample         (head_sample),
    .empty               (empty),
    .err_stat            (err_stat),
    .underflow_count     (underflow_count),
    .read_count          (read_count),
    .read_count_freeze   (read_count_freeze)
  );

  adc_capture_ctrl i_adc_capture_ctrl (
    .clk_usb      (clk_usb),
    .reset        (reset),
    .trig         (trig),
    .adc_valid    (adc_valid),
    .adc_data     (adc_data),
    .seg_len      (seg_len),
    .push         (push),
    .push_data    (push_data),
    .capture_done (capture_done)
  );

endmodule

// File: reg_adcfifo.sv
`timescale 1ns/100ps

module reg_adcfifo (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  adcfifo_pkg::reg_bus_t    reg_bus,             // host register bus
  output adcfifo_pkg::reg_byte_t   reg_datao,           // read data, 0 when not reading
  input  adcfifo_pkg::adc_sample_t head_sample,         // fwft head of sample fifo
  input  logic                     empty,
  input  adcfifo_pkg::fifo_err_t   err_stat,
  input  adcfifo_pkg::reg_byte_t   underflow_count,
  input  logic [31:0]              read_count,          // accepted pops
  input  logic [31:0]              read_count_freeze,   // pops before first error
  input  logic                     capture_done,
  output logic                     pop,                 // fifo read enable
  output logic                     clear_errors,        // one-cycle pulse
  output logic                     fast_mode,           // fast fifo read mode
  output logic                     no_underflow_errors, // mask slow underflow flag
  output adcfifo_pkg::seg_len_t    seg_len              // samples per capture
);

  import adcfifo_pkg::*;

  logic      low_res;      // 8-bit sample readout
  logic      low_res_lsb;  // low byte rather than high byte in low_res
  logic      read_r;       // read strobe, previous cycle
  logic      read_edge;    // rise of read at the sample address
  logic      pop_slow;     // slow-mode pop, one cycle after the rise
  reg_byte_t sample_byte;  // formatted head sample

  // byte select for multibyte registers, little endian
  function automatic reg_byte_t pick_byte(input logic [31:0] word, input bytecnt_t idx);
    reg_byte_t b;
    case (idx)
      bytecnt_t'(0): b = word[7:0];
      bytecnt_t'(1): b = word[15:8];
      bytecnt_t'(2): b = word[23:16];
      bytecnt_t'(3): b = word[31:24];
      default:       b = '0;       // past the widest register
    endcase
    return b;
  endfunction

  // sample formatting by resolution mode
  always_comb begin
    if (!low_res)
      sample_byte = pick_byte({22'b0, head_sample}, reg_bus.bytecnt);  // 16-bit, two bytes
    else if (low_res_lsb)
      sample_byte = head_sample[7:0];  // drop top two bits
    else
      sample_byte = head_sample[9:2];  // drop bottom two bits
  end

  // read mux
  always_comb begin
    reg_datao = '0;
    if (reg_bus.read) begin
      case (reg_bus.address)
        ADDR_ADCREAD:
          reg_datao = sample_byte;
        ADDR_FIFO_STAT:
          reg_datao = pick_byte({23'b0, empty, err_stat}, reg_bus.bytecnt);  // empty in byte 1
        ADDR_ADC_LOW_RES:
          reg_datao = {6'b0, low_res_lsb, low_res};
        ADDR_FAST_FIFO_READ_MODE:
          reg_datao = {7'b0, fast_mode};
        ADDR_STREAM_SEGMENT_THRESHOLD:
          reg_datao = pick_byte({15'b0, seg_len}, reg_bus.bytecnt);
        ADDR_FIFO_UNDERFLOW_COUNT:
          reg_datao = underflow_count;
        ADDR_FIFO_NO_UNDERFLOW_ERROR:
          reg_datao = {7'b0, no_underflow_errors};
        ADDR_CAPTURE_DONE:
          reg_datao = {7'b0, capture_done};
        ADDR_DEBUG_FIFO_READS:
          reg_datao = pick_byte(read_count, reg_bus.bytecnt);
        ADDR_DEBUG_FIFO_READS_FREEZE:
          reg_datao = pick_byte(read_count_freeze, reg_bus.bytecnt);
        default:
          reg_datao = '0;  // unmapped
      endcase
    end
  end

  // readout settings
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res             <= 1'b0;
      low_res_lsb         <= 1'b0;
      no_underflow_errors <= 1'b1;  // slow underflow counted only
      seg_len             <= SEG_LEN_RESET;
    end else if (reg_bus.write) begin
      case (reg_bus.address)
        ADDR_ADC_LOW_RES: begin
          low_res     <= reg_bus.datai[0];
          low_res_lsb <= reg_bus.datai[1];
        end
        ADDR_STREAM_SEGMENT_THRESHOLD: begin
          case (reg_bus.bytecnt)
            bytecnt_t'(0): seg_len[7:0]  <= reg_bus.datai;
            bytecnt_t'(1): seg_len[15:8] <= reg_bus.datai;
            bytecnt_t'(2): seg_len[16]   <= reg_bus.datai[0];  // only bit 16 exists
            default: ;
          endcase
        end
        ADDR_FIFO_NO_UNDERFLOW_ERROR:
          no_underflow_errors <= reg_bus.datai[0];
        default: ;
      endcase
    end
  end

  // fast mode lasts until any other register is written
  always_ff @(posedge clk_usb) begin
    if (reset)
      fast_mode <= 1'b0;
    else if (reg_bus.write)
      fast_mode <= (reg_bus.address == ADDR_FAST_FIFO_READ_MODE) && reg_bus.datai[0];
  end

  // write to status register clears fifo errors
  always_ff @(posedge clk_usb) begin
    if (reset)
      clear_errors <= 1'b0;
    else
      clear_errors <= reg_bus.write && (reg_bus.address == ADDR_FIFO_STAT);
  end

  assign read_edge = reg_bus.read && !read_r && (reg_bus.address == ADDR_ADCREAD);

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_r   <= 1'b0;
      pop_slow <= 1'b0;
    end else begin
      read_r   <= reg_bus.read;
      pop_slow <= read_edge && !fast_mode;  // no second pop after a fast one
    end
  end

  // fast mode saves a cycle by popping on the rise itself
  assign pop = fast_mode ? read_edge : pop_slow;

endmodule

// File: src.f
adcfifo_pkg.sv
adc_sample_fifo.sv
adc_capture_ctrl.sv
reg_adcfifo.sv
adcfifo_top.sv
adcfifo_chk.sv
tb_clkgen.sv
tb_adcfifo.sv

// File: tb_adcfifo.sv
`timescale 1ns/100ps

module tb_adcfifo;

  import adcfifo_pkg::*;

  localparam int MAX_CYCLES = 4000;  // bus traffic ends well under 1000 cycles

  logic        clk_usb;
  logic        reset;
  reg_bus_t    reg_bus;
  reg_byte_t   reg_datao;
  logic        trig;
  logic        adc_valid;
  adc_sample_t adc_data;

  adc_sample_t model_q[$];     // samples held in the fifo, oldest first
  integer      seed = 53660;
  int          errors = 0;     // failed compares
  int          checks = 0;
  int          cycles = 0;
  int          chk_errors;     // failures in the bound checker
  logic [31:0] rd;             // don't-care read data

  tb_clkgen i_tb_clkgen (.clk_usb(clk_usb), .reset(reset));

  adcfifo_top i_adcfifo_top (
    .clk_usb   (clk_usb),
    .reset     (reset),
    .reg_bus   (reg_bus),
    .reg_datao (reg_datao),
    .trig      (trig),
    .adc_valid (adc_valid),
    .adc_data  (adc_data)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    assert (got == want) else begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  // one-cycle strobe, then a cycle idle
  task automatic reg_write(input reg_addr_t addr, input int idx, input reg_byte_t data);
    @(posedge clk_usb);
    reg_bus.address <= addr;
    reg_bus.bytecnt <= bytecnt_t'(idx);
    reg_bus.datai   <= data;
    reg_bus.write   <= 1'b1;
    @(posedge clk_usb);
    reg_bus.write   <= 1'b0;
  endtask

  // read stays high over all bytes, data taken mid-cycle
  task automatic reg_read(input reg_addr_t addr, input int nbytes, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < nbytes; b++) begin
      @(posedge clk_usb);
      reg_bus.address <= addr;
      reg_bus.bytecnt <= bytecnt_t'(b);  // little endian
      reg_bus.read    <= 1'b1;
      @(negedge clk_usb);
      val[8*b +: 8] = reg_datao;
    end
    @(posedge clk_usb);
    reg_bus.read <= 1'b0;  // low for a cycle before next rise
  endtask

  task automatic expect_reg(input string name, input reg_addr_t addr, input int nbytes,
                            input logic [31:0] want);
    logic [31:0] got;
    reg_read(addr, nbytes, got);
    compare_value(name, got, want);
  endtask

  task automatic write_seg_len(input int n);
    reg_write(ADDR_STREAM_SEGMENT_THRESHOLD, 0, reg_byte_t'(n));
    reg_write(ADDR_STREAM_SEGMENT_THRESHOLD, 1, reg_byte_t'(n >> 8));
    reg_write(ADDR_STREAM_SEGMENT_THRESHOLD, 2, reg_byte_t'(n >> 16));
  endtask

  // fmt 0 full 16-bit, 1 low_res top bits, 2 low_res bottom bits
  task automatic read_samples(input int n, input int fmt);
    adc_sample_t s;
    logic [31:0] got;
    logic [31:0] want;
    for (int i = 0; i < n; i++) begin
      s = model_q.pop_front();
      reg_read(ADDR_ADCREAD, (fmt == 0) ? 2 : 1, got);
      case (fmt)
        0:       want = {22'b0, s};       // zero extended, two bytes
        1:       want = {24'b0, s[9:2]};
        default: want = {24'b0, s[7:0]};
      endcase
      compare_value("reg_datao at ADDR_ADCREAD", got, want);
    end
  endtask

  // trigger, n valid samples with random gaps, then poll capture_done
  task automatic run_capture(input int n);
    int          sent;
    int          polls;
    logic [31:0] r;
    logic [31:0] done;
    sent = 0;
    polls = 0;
    done = '0;
    @(posedge clk_usb);
    trig <= 1'b1;
    @(posedge clk_usb);
    trig <= 1'b0;  // run state from here
    while (sent < n) begin
      r = $random(seed);
      if (r[12]) begin
        adc_valid <= 1'b0;  // gap
      end else begin
        adc_valid <= 1'b1;
        adc_data  <= r[9:0];
        if (model_q.size() < FIFO_DEPTH)
          model_q.push_back(r[9:0]);  // full fifo drops it
        sent++;
      end
      @(posedge clk_usb);
    end
    adc_valid <= 1'b0;
    while (done == 0 && polls < 100) begin
      reg_read(ADDR_CAPTURE_DONE, 1, done);
      polls++;
    end
    checks++;
    assert (done == 1) else begin
      $display("capture_done still low after %0d polls", polls);
      errors++;
    end
  endtask

  initial begin
    reg_bus   = '0;
    trig      = 1'b0;
    adc_valid = 1'b0;
    adc_data  = '0;
    while (reset !== 1'b0)
      @(posedge clk_usb);

    // reset values
    expect_reg("segment length", ADDR_STREAM_SEGMENT_THRESHOLD, 3, 32'h01_0000);
    expect_reg("underflow policy", ADDR_FIFO_NO_UNDERFLOW_ERROR, 1, 32'h1);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0100);  // empty, no errors
    expect_reg("capture_done", ADDR_CAPTURE_DONE, 1, 32'h0);

    // write and readback
    write_seg_len(10);
    expect_reg("segment length", ADDR_STREAM_SEGMENT_THRESHOLD, 3, 32'd10);
    reg_write(ADDR_ADC_LOW_RES, 0, 8'h03);
    expect_reg("low_res bits", ADDR_ADC_LOW_RES, 1, 32'h3);
    reg_write(ADDR_FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    expect_reg("underflow policy", ADDR_FIFO_NO_UNDERFLOW_ERROR, 1, 32'h0);
    reg_write(ADDR_FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);
    reg_write(ADDR_FAST_FIFO_READ_MODE, 0, 8'h01);
    expect_reg("fast mode", ADDR_FAST_FIFO_READ_MODE, 1, 32'h1);
    reg_write(ADDR_ADC_LOW_RES, 0, 8'h00);  // other address ends fast mode
    expect_reg("fast mode", ADDR_FAST_FIFO_READ_MODE, 1, 32'h0);

    // slow full-resolution readout
    run_capture(10);
    read_samples(10, 0);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0100);

    // fast readout, high then low byte of low_res
    run_capture(10);
    reg_write(ADDR_ADC_LOW_RES, 0, 8'h01);
    reg_write(ADDR_FAST_FIFO_READ_MODE, 0, 8'h01);  // last write, stays set
    read_samples(5, 1);
    reg_write(ADDR_ADC_LOW_RES, 0, 8'h03);
    reg_write(ADDR_FAST_FIFO_READ_MODE, 0, 8'h01);
    read_samples(5, 2);
    expect_reg("read count", ADDR_DEBUG_FIFO_READS, 4, 32'd20);

    // underflow in fast mode
    reg_read(ADDR_ADCREAD, 1, rd);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0102);
    expect_reg("underflow count", ADDR_FIFO_UNDERFLOW_COUNT, 1, 32'd1);
    expect_reg("read count", ADDR_DEBUG_FIFO_READS, 4, 32'd20);
    expect_reg("frozen read count", ADDR_DEBUG_FIFO_READS_FREEZE, 4, 32'd20);
    reg_write(ADDR_FIFO_STAT, 0, 8'h00);  // clears errors, also fast mode
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0100);

    // slow mode, policy 1 only counts
    reg_read(ADDR_ADCREAD, 1, rd);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0100);
    expect_reg("underflow count", ADDR_FIFO_UNDERFLOW_COUNT, 1, 32'd2);

    // slow mode, policy 0 flags bit 2
    reg_write(ADDR_FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    reg_read(ADDR_ADCREAD, 1, rd);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0104);
    expect_reg("underflow count", ADDR_FIFO_UNDERFLOW_COUNT, 1, 32'd3);
    reg_write(ADDR_FIFO_STAT, 0, 8'h00);
    reg_write(ADDR_FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);

    // 40 samples into 32 entries
    write_seg_len(40);
    reg_write(ADDR_ADC_LOW_RES, 0, 8'h00);
    run_capture(40);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0001);  // overflow, not empty
    read_samples(FIFO_DEPTH, 0);
    expect_reg("fifo status", ADDR_FIFO_STAT, 2, 32'h0101);
    expect_reg("read count", ADDR_DEBUG_FIFO_READS, 4, 32'd52);
    expect_reg("frozen read count", ADDR_DEBUG_FIFO_READS_FREEZE, 4, 32'd20);
    reg_write(ADDR_FIFO_STAT, 0, 8'h00);  // freeze released
    expect_reg("frozen read count", ADDR_DEBUG_FIFO_READS_FREEZE, 4, 32'd52);

    chk_errors = i_adcfifo_top.i_reg_adcfifo.i_adcfifo_chk.fail_count;
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             checks, errors, chk_errors);
    if (errors == 0 && chk_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  always @(posedge clk_usb) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_usb,  // 8 ns period
  output logic reset     // active high, synchronous use
);

  initial begin
    clk_usb = 1'b0;
    forever #4 clk_usb = ~clk_usb;  // half period
  end

  // held across two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk_usb);
    reset <= 1'b0;
  end

endmodule
